// ==== offload_pkg.sv ====
/*
 * Offload request and response definitions
 * Field widths, payload types and target address codes
 */
package offload_pkg;

  // ----------------------------------------
  // Field widths
  // ----------------------------------------
  localparam int unsigned IdWidth   = 5;
  localparam int unsigned DataWidth = 32;
  localparam int unsigned AddrWidth = 2;
  localparam int unsigned OpWidth   = 32;

  // ----------------------------------------
  // Field types
  // ----------------------------------------
  typedef logic [IdWidth-1:0]   id_t;
  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [DataWidth-1:0] data_t;
  typedef logic [OpWidth-1:0]   op_t;

  // ----------------------------------------
  // Target decode
  // ----------------------------------------
  // External accelerator port
  localparam addr_t TargetAcc = 2'd0;
  // Stream configuration registers
  localparam addr_t TargetCfg = 2'd1;
  // Remaining addresses fall through to the error responder

endpackage

// ==== ssr_cfg_pkg.sv ====
/*
 * Stream configuration unit definitions
 * Opcodes, register count and word types
 */
package ssr_cfg_pkg;

  // Register file size
  localparam int unsigned NumCfgWords  = 8;
  localparam int unsigned CfgWordWidth = $clog2(NumCfgWords);
  localparam int unsigned CfgDataWidth = 32;

  // Register index, low bits of operand b
  typedef logic [CfgWordWidth-1:0] cfg_word_t;
  typedef logic [CfgDataWidth-1:0] cfg_data_t;

  // Opcodes, anything other than a write reads
  localparam logic [31:0] CfgOpRead  = 32'd1;
  localparam logic [31:0] CfgOpWrite = 32'd2;

endpackage

// ==== offload_credit_if.sv ====
/*
 * Credit based push channel
 * Carries one offload request per valid cycle and a credit return
 */
`timescale 1ns/1ns

interface offload_credit_if;
  import offload_pkg::*;

  // Request push, one credit spent per valid cycle
  logic  valid;
  id_t   id;
  addr_t addr;
  op_t   op;
  data_t arga;
  data_t argb;

  // One pulse per freed queue entry
  logic  credit;

  modport issuer (
    output valid, id, addr, op, arga, argb,
    input  credit
  );

  modport receiver (
    input  valid, id, addr, op, arga, argb,
    output credit
  );

endinterface

// ==== offload_issue.sv ====
/*
 * Offload issue stage
 * Accepts requests while credits remain and pushes them to the queue
 */
`timescale 1ns/1ns

module offload_issue #(
  parameter int unsigned QueueDepth = 4
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                req_valid_i,
  input  offload_pkg::id_t    req_id_i,
  input  offload_pkg::addr_t  req_addr_i,
  input  offload_pkg::op_t    req_op_i,
  input  offload_pkg::data_t  req_arga_i,
  input  offload_pkg::data_t  req_argb_i,
  output logic                req_ready_o,
  offload_credit_if.issuer    push_o
);

  localparam int unsigned CntWidth = $clog2(QueueDepth + 1);

  logic [CntWidth-1:0] credit_cnt_q;
  logic                issue_en_q;
  logic                push;

  // Ready as long as one queue slot is known free
  assign req_ready_o = issue_en_q && (credit_cnt_q != '0);
  assign push        = req_valid_i && req_ready_o;

  // Fields go straight through, the queue captures them on push
  assign push_o.valid = push;
  assign push_o.id    = req_id_i;
  assign push_o.addr  = req_addr_i;
  assign push_o.op    = req_op_i;
  assign push_o.arga  = req_arga_i;
  assign push_o.argb  = req_argb_i;

  // Credit counter, starts with the whole queue free
  always_ff @(posedge clk_i) begin
    if (rst_ni) begin
      credit_cnt_q <= CntWidth'(QueueDepth);
      issue_en_q   <= 1'b0;
    end else begin
      issue_en_q <= 1'b1;
      case ({push, push_o.credit})
        2'b10:   credit_cnt_q <= credit_cnt_q - CntWidth'(1);
        2'b01:   credit_cnt_q <= credit_cnt_q + CntWidth'(1);
        default: credit_cnt_q <= credit_cnt_q;
      endcase
    end
  end

endmodule

// ==== offload_queue.sv ====
/*
 * Offload request queue
 * Circular FIFO, returns one credit per popped entry
 */
`timescale 1ns/1ns

module offload_queue #(
  parameter int unsigned QueueDepth = 4
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  offload_credit_if.receiver  push_i,
  output logic                head_valid_o,
  output offload_pkg::id_t    head_id_o,
  output offload_pkg::addr_t  head_addr_o,
  output offload_pkg::op_t    head_op_o,
  output offload_pkg::data_t  head_arga_o,
  output offload_pkg::data_t  head_argb_o,
  input  logic                pop_i
);
  import offload_pkg::*;

  localparam int unsigned PtrWidth = (QueueDepth > 1) ? $clog2(QueueDepth) : 1;
  localparam int unsigned CntWidth = $clog2(QueueDepth + 1);

  id_t   mem_id   [QueueDepth];
  addr_t mem_addr [QueueDepth];
  op_t   mem_op   [QueueDepth];
  data_t mem_arga [QueueDepth];
  data_t mem_argb [QueueDepth];

  logic [PtrWidth-1:0] wr_ptr_q, rd_ptr_q;
  logic [CntWidth-1:0] count_q;
  logic                do_pop;
  logic                credit_q;

  function automatic logic [PtrWidth-1:0] next_ptr(input logic [PtrWidth-1:0] ptr);
    if (ptr == PtrWidth'(QueueDepth - 1)) return '0;
    return ptr + PtrWidth'(1);
  endfunction

  assign head_valid_o = (count_q != '0);
  assign do_pop       = pop_i && head_valid_o;

  assign head_id_o   = mem_id[rd_ptr_q];
  assign head_addr_o = mem_addr[rd_ptr_q];
  assign head_op_o   = mem_op[rd_ptr_q];
  assign head_arga_o = mem_arga[rd_ptr_q];
  assign head_argb_o = mem_argb[rd_ptr_q];

  assign push_i.credit = credit_q;

  // Storage, the credit scheme guarantees a free slot on every push
  always_ff @(posedge clk_i) begin
    if (push_i.valid) begin
      mem_id[wr_ptr_q]   <= push_i.id;
      mem_addr[wr_ptr_q] <= push_i.addr;
      mem_op[wr_ptr_q]   <= push_i.op;
      mem_arga[wr_ptr_q] <= push_i.arga;
      mem_argb[wr_ptr_q] <= push_i.argb;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      credit_q <= 1'b0;
    end else begin
      if (push_i.valid) wr_ptr_q <= next_ptr(wr_ptr_q);
      if (do_pop)       rd_ptr_q <= next_ptr(rd_ptr_q);
      case ({push_i.valid, do_pop})
        2'b10:   count_q <= count_q + CntWidth'(1);
        2'b01:   count_q <= count_q - CntWidth'(1);
        default: count_q <= count_q;
      endcase
      // Freed slot goes back to the issuer next cycle
      credit_q <= do_pop;
    end
  end

endmodule

// ==== ssr_cfg_unit.sv ====
/*
 * Stream configuration register unit
 * Reads and writes configuration words, one request at a time
 */
`timescale 1ns/1ns

module ssr_cfg_unit (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                req_valid_i,
  input  offload_pkg::id_t    req_id_i,
  input  offload_pkg::op_t    req_op_i,
  input  offload_pkg::data_t  req_arga_i,
  input  offload_pkg::data_t  req_argb_i,
  output logic                req_ready_o,
  output logic                rsp_valid_o,
  output offload_pkg::id_t    rsp_id_o,
  output offload_pkg::data_t  rsp_data_o,
  input  logic                rsp_ready_i
);
  import offload_pkg::*;
  import ssr_cfg_pkg::*;

  cfg_data_t cfg_q [NumCfgWords];
  cfg_word_t word;
  logic      is_write;
  logic      accept;
  logic      rsp_valid_q;
  id_t       rsp_id_q;
  data_t     rsp_data_q;

  assign word     = req_argb_i[CfgWordWidth-1:0];
  assign is_write = (req_op_i == CfgOpWrite);

  // Idle once the previous response has been taken
  assign req_ready_o = !rsp_valid_q;
  assign accept      = req_valid_i && req_ready_o;

  assign rsp_valid_o = rsp_valid_q;
  assign rsp_id_o    = rsp_id_q;
  assign rsp_data_o  = rsp_data_q;

  always_ff @(posedge clk_i) begin
    if (rst_ni) begin
      rsp_valid_q <= 1'b0;
      for (int i = 0; i < NumCfgWords; i++) cfg_q[i] <= '0;
    end else begin
      if (accept) begin
        rsp_valid_q <= 1'b1;
        if (is_write) cfg_q[word] <= req_arga_i;
      end else if (rsp_ready_i) begin
        rsp_valid_q <= 1'b0;
      end
    end
  end

  // Writes answer with the old value and id 0, so nothing is written back
  always_ff @(posedge clk_i) begin
    if (accept) begin
      rsp_id_q   <= is_write ? id_t'(0) : req_id_i;
      rsp_data_q <= cfg_q[word];
    end
  end

endmodule

// ==== offload_dispatch.sv ====
/*
 * Offload dispatcher
 * Routes queue heads by target and merges all responses round-robin
 */
`timescale 1ns/1ns

module offload_dispatch (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                head_valid_i,
  input  offload_pkg::id_t    head_id_i,
  input  offload_pkg::addr_t  head_addr_i,
  input  offload_pkg::op_t    head_op_i,
  input  offload_pkg::data_t  head_arga_i,
  input  offload_pkg::data_t  head_argb_i,
  output logic                pop_o,
  output logic                acc_q_valid_o,
  output offload_pkg::id_t    acc_q_id_o,
  output offload_pkg::op_t    acc_q_op_o,
  output offload_pkg::data_t  acc_q_arga_o,
  output offload_pkg::data_t  acc_q_argb_o,
  input  logic                acc_q_ready_i,
  input  logic                acc_p_valid_i,
  input  offload_pkg::id_t    acc_p_id_i,
  input  offload_pkg::data_t  acc_p_data_i,
  input  logic                acc_p_error_i,
  output logic                acc_p_ready_o,
  output logic                resp_valid_o,
  output offload_pkg::id_t    resp_id_o,
  output offload_pkg::data_t  resp_data_o,
  output logic                resp_error_o,
  input  logic                resp_ready_i
);
  import offload_pkg::*;

  localparam int unsigned NumSrc = 3;
  localparam logic [1:0]  SrcAcc = 2'd0;
  localparam logic [1:0]  SrcCfg = 2'd1;
  localparam logic [1:0]  SrcErr = 2'd2;

  logic  to_acc, to_cfg, to_err;
  logic  cfg_req_ready;
  logic  cfg_rsp_valid, cfg_rsp_ready;
  id_t   cfg_rsp_id;
  data_t cfg_rsp_data;
  logic  err_take, err_valid_q;
  id_t   err_id_q;
  logic  [NumSrc-1:0] src_valid, src_error;
  id_t   src_id   [NumSrc];
  data_t src_data [NumSrc];
  logic  [1:0] grant, rr_q;
  logic  resp_hs;

  // ----------------------------------------
  // Target decode
  // ----------------------------------------
  assign to_acc = head_valid_i && (head_addr_i == TargetAcc);
  assign to_cfg = head_valid_i && (head_addr_i == TargetCfg);
  assign to_err = head_valid_i && !(head_addr_i inside {TargetAcc, TargetCfg});

  assign acc_q_valid_o = to_acc;
  assign acc_q_id_o    = head_id_i;
  assign acc_q_op_o    = head_op_i;
  assign acc_q_arga_o  = head_arga_i;
  assign acc_q_argb_o  = head_argb_i;

  assign err_take = to_err && !err_valid_q;
  assign pop_o    = (to_acc && acc_q_ready_i) || (to_cfg && cfg_req_ready) || err_take;

  ssr_cfg_unit i_ssr_cfg_unit (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_valid_i (to_cfg),
    .req_id_i    (head_id_i),
    .req_op_i    (head_op_i),
    .req_arga_i  (head_arga_i),
    .req_argb_i  (head_argb_i),
    .req_ready_o (cfg_req_ready),
    .rsp_valid_o (cfg_rsp_valid),
    .rsp_id_o    (cfg_rsp_id),
    .rsp_data_o  (cfg_rsp_data),
    .rsp_ready_i (cfg_rsp_ready)
  );

  // Error slot holds one undecoded request until its response leaves
  always_ff @(posedge clk_i) begin
    if (rst_ni) begin
      err_valid_q <= 1'b0;
    end else if (err_take) begin
      err_valid_q <= 1'b1;
    end else if (resp_hs && (grant == SrcErr)) begin
      err_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (err_take) err_id_q <= head_id_i;
  end

  // ----------------------------------------
  // Response arbiter
  // ----------------------------------------
  assign src_valid = {err_valid_q, cfg_rsp_valid, acc_p_valid_i};
  assign src_error = {1'b1, 1'b0, acc_p_error_i};
  assign src_id[SrcAcc]   = acc_p_id_i;
  assign src_id[SrcCfg]   = cfg_rsp_id;
  assign src_id[SrcErr]   = err_id_q;
  assign src_data[SrcAcc] = acc_p_data_i;
  assign src_data[SrcCfg] = cfg_rsp_data;
  assign src_data[SrcErr] = '0;

  // First valid source at or after the round-robin pointer
  always_comb begin : rr_select
    int unsigned idx;
    grant        = SrcAcc;
    resp_valid_o = 1'b0;
    for (int unsigned i = 0; i < NumSrc; i++) begin
      idx = (rr_q + i) % NumSrc;
      if (!resp_valid_o && src_valid[idx]) begin
        resp_valid_o = 1'b1;
        grant        = 2'(idx);
      end
    end
  end

  assign resp_id_o    = src_id[grant];
  assign resp_data_o  = src_data[grant];
  assign resp_error_o = src_error[grant];
  assign resp_hs      = resp_valid_o && resp_ready_i;

  assign acc_p_ready_o = resp_hs && (grant == SrcAcc);
  assign cfg_rsp_ready = resp_hs && (grant == SrcCfg);

  always_ff @(posedge clk_i) begin
    if (rst_ni) begin
      rr_q <= SrcAcc;
    end else if (resp_hs) begin
      rr_q <= (grant == SrcErr) ? SrcAcc : grant + 2'd1;
    end
  end

endmodule

// ==== offload_top.sv ====
/*
 * Offload path top level
 * Issue stage, request queue and dispatcher behind plain valid/ready ports
 */
`timescale 1ns/1ns

module offload_top #(
  parameter int unsigned QueueDepth = 4
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  // Incoming requests
  input  logic                req_valid_i,
  input  offload_pkg::id_t    req_id_i,
  input  offload_pkg::addr_t  req_addr_i,
  input  offload_pkg::op_t    req_op_i,
  input  offload_pkg::data_t  req_arga_i,
  input  offload_pkg::data_t  req_argb_i,
  output logic                req_ready_o,
  // External accelerator request
  output logic                acc_q_valid_o,
  output offload_pkg::id_t    acc_q_id_o,
  output offload_pkg::op_t    acc_q_op_o,
  output offload_pkg::data_t  acc_q_arga_o,
  output offload_pkg::data_t  acc_q_argb_o,
  input  logic                acc_q_ready_i,
  // External accelerator response
  input  logic                acc_p_valid_i,
  input  offload_pkg::id_t    acc_p_id_i,
  input  offload_pkg::data_t  acc_p_data_i,
  input  logic                acc_p_error_i,
  output logic                acc_p_ready_o,
  // Merged responses
  output logic                resp_valid_o,
  output offload_pkg::id_t    resp_id_o,
  output offload_pkg::data_t  resp_data_o,
  output logic                resp_error_o,
  input  logic                resp_ready_i
);
  import offload_pkg::*;

  offload_credit_if push_if ();

  logic  head_valid, pop;
  id_t   head_id;
  addr_t head_addr;
  op_t   head_op;
  data_t head_arga, head_argb;

  offload_issue #(.QueueDepth(QueueDepth)) i_offload_issue (
    .clk_i, .rst_ni,
    .req_valid_i, .req_id_i, .req_addr_i, .req_op_i, .req_arga_i, .req_argb_i,
    .req_ready_o,
    .push_o (push_if.issuer)
  );

  offload_queue #(.QueueDepth(QueueDepth)) i_offload_queue (
    .clk_i, .rst_ni,
    .push_i       (push_if.receiver),
    .head_valid_o (head_valid),
    .head_id_o    (head_id),
    .head_addr_o  (head_addr),
    .head_op_o    (head_op),
    .head_arga_o  (head_arga),
    .head_argb_o  (head_argb),
    .pop_i        (pop)
  );

  offload_dispatch i_offload_dispatch (
    .clk_i, .rst_ni,
    .head_valid_i (head_valid),
    .head_id_i    (head_id),
    .head_addr_i  (head_addr),
    .head_op_i    (head_op),
    .head_arga_i  (head_arga),
    .head_argb_i  (head_argb),
    .pop_o        (pop),
    .acc_q_valid_o, .acc_q_id_o, .acc_q_op_o, .acc_q_arga_o, .acc_q_argb_o,
    .acc_q_ready_i,
    .acc_p_valid_i, .acc_p_id_i, .acc_p_data_i, .acc_p_error_i, .acc_p_ready_o,
    .resp_valid_o, .resp_id_o, .resp_data_o, .resp_error_o, .resp_ready_i
  );

endmodule

// ==== tb_clock_gen.sv ====
/*
 * Testbench clock and reset generator
 */
`timescale 1ns/1ns

module tb_clock_gen #(
  parameter int unsigned Period      = 20,
  parameter int unsigned ResetCycles = 8
) (
  output logic clk_o,
  output logic rst_o
);

  initial begin
    clk_o = 1'b0;
    forever
      #(Period / 2) clk_o = ~clk_o;
  end

  // Released right after the last reset edge
  initial begin
    rst_o = 1'b1;
    repeat (ResetCycles) @(posedge clk_o);
    rst_o <= 1'b0;
  end

endmodule

// ==== tb_offload_top.sv ====
/*
 * Offload path testbench
 * Drives requests from the stimulus file, models the external
 * accelerator and checks every merged response
 */
`timescale 1ns/1ns

module tb_offload_top;
  import offload_pkg::*;

  localparam int unsigned QueueDepth  = 4;
  localparam int unsigned MaxReq      = 40;
  localparam int unsigned StallCycles = 20;

  logic  clk_i;
  logic  rst_ni;

  // DUT inputs
  logic  req_valid_i   = 1'b0;
  id_t   req_id_i      = '0;
  addr_t req_addr_i    = '0;
  op_t   req_op_i      = '0;
  data_t req_arga_i    = '0;
  data_t req_argb_i    = '0;
  logic  acc_q_ready_i = 1'b0;
  logic  acc_p_valid_i = 1'b0;
  id_t   acc_p_id_i    = '0;
  data_t acc_p_data_i  = '0;
  logic  acc_p_error_i = 1'b0;
  logic  resp_ready_i  = 1'b0;

  // DUT outputs
  logic  req_ready_o, acc_q_valid_o, acc_p_ready_o;
  id_t   acc_q_id_o;
  op_t   acc_q_op_o;
  data_t acc_q_arga_o, acc_q_argb_o;
  logic  resp_valid_o, resp_error_o;
  id_t   resp_id_o;
  data_t resp_data_o;

  // Stimulus of nine words per request
  logic [31:0] stim [9*MaxReq];
  int          num_req;
  bit          loaded;

  // Expected results by response id and request fields by request id
  data_t exp_data_tab [32];
  logic  exp_err_tab  [32];
  op_t   req_op_tab   [32];
  data_t req_arga_tab [32];
  data_t req_argb_tab [32];
  int    issued_cnt   [32];
  int    done_cnt     [32];

  int    resp_errors, protocol_errors, flow_errors;
  int    pushed_count, resp_count;
  // 0 always ready, 1 random, 2 held low
  int    resp_mode;

  // Accelerator model state
  id_t         acc_id_buf   [64];
  data_t       acc_data_buf [64];
  logic [5:0]  acc_wr = '0;
  logic [5:0]  acc_rd = '0;
  int          acc_delay, acc_p_done, acc_p_seen;
  logic [31:0] rand_state = 32'd67688;

  tb_clock_gen clock_gen_inst (
    .clk_o (clk_i),
    .rst_o (rst_ni)
  );

  offload_top #(.QueueDepth(QueueDepth)) offload_top_inst (.*);

  function logic [31:0] next_rand();
    rand_state = rand_state * 32'd1103515245 + 32'd12345;
    return rand_state >> 16;
  endfunction

  function automatic logic [31:0] stim_field(input int idx, input int col);
    return stim[idx * 9 + col];
  endfunction

  task automatic note_resp_mismatch(input string name, input logic [31:0] expected,
                                    input logic [31:0] actual);
    resp_errors++;
    $display("error at %0t: %s expected %h actual %h", $time, name, expected, actual);
  endtask

  task automatic note_flow_mismatch(input string name, input logic [31:0] expected,
                                    input logic [31:0] actual);
    flow_errors++;
    $display("error at %0t: %s expected %h actual %h", $time, name, expected, actual);
  endtask

  // ----------------------------------------
  // Accelerator and response-side drive
  // ----------------------------------------
  always @(negedge clk_i) begin
    if (!rst_ni) begin
      acc_q_ready_i = (next_rand() % 4) != 0;
      if (resp_mode == 1)
        resp_ready_i = (next_rand() % 3) != 0;
      else
        resp_ready_i = (resp_mode == 0);
      // Next result only once the previous one was taken
      if (!acc_p_valid_i || (acc_p_done != acc_p_seen)) begin
        acc_p_seen    = acc_p_done;
        acc_p_valid_i = 1'b0;
        if (acc_delay > 0) begin
          acc_delay--;
        end else if (acc_rd != acc_wr) begin
          acc_p_valid_i = 1'b1;
          acc_p_id_i    = acc_id_buf[acc_rd];
          acc_p_data_i  = acc_data_buf[acc_rd];
          acc_rd        = acc_rd + 6'd1;
          acc_delay     = int'(next_rand() % 4);
        end
      end
    end
  end

  // ----------------------------------------
  // Handshake monitor
  // ----------------------------------------
  always @(posedge clk_i) begin
    if (!rst_ni) begin
      if (acc_q_valid_o && acc_q_ready_i) begin
        if (acc_q_op_o !== req_op_tab[acc_q_id_o])
          note_resp_mismatch("acc_q_op_o", req_op_tab[acc_q_id_o], acc_q_op_o);
        if (acc_q_arga_o !== req_arga_tab[acc_q_id_o])
          note_resp_mismatch("acc_q_arga_o", req_arga_tab[acc_q_id_o], acc_q_arga_o);
        if (acc_q_argb_o !== req_argb_tab[acc_q_id_o])
          note_resp_mismatch("acc_q_argb_o", req_argb_tab[acc_q_id_o], acc_q_argb_o);
        // Accelerator result is the operand sum
        acc_id_buf[acc_wr]   = acc_q_id_o;
        acc_data_buf[acc_wr] = acc_q_arga_o + acc_q_argb_o;
        acc_wr               = acc_wr + 6'd1;
      end
      if (acc_p_valid_i && acc_p_ready_o)
        acc_p_done++;
      if (resp_valid_o && resp_ready_i) begin
        if (issued_cnt[resp_id_o] == done_cnt[resp_id_o]) begin
          protocol_errors++;
          $display("Response with id %0d at %0t matches no outstanding request",
                   resp_id_o, $time);
        end else begin
          if (resp_data_o !== exp_data_tab[resp_id_o])
            note_resp_mismatch("resp_data_o", exp_data_tab[resp_id_o], resp_data_o);
          if (resp_error_o !== exp_err_tab[resp_id_o])
            note_resp_mismatch("resp_error_o", 32'(exp_err_tab[resp_id_o]),
                               32'(resp_error_o));
          done_cnt[resp_id_o]++;
        end
        resp_count++;
      end
    end
  end

  // Issues one request from the list and returns after its handshake
  task automatic push_entry(input int idx);
    id_t id;
    id_t exp_id;
    id                   = id_t'(stim_field(idx, 1));
    exp_id               = id_t'(stim_field(idx, 6));
    req_op_tab[id]       = stim_field(idx, 3);
    req_arga_tab[id]     = stim_field(idx, 4);
    req_argb_tab[id]     = stim_field(idx, 5);
    exp_data_tab[exp_id] = stim_field(idx, 7);
    exp_err_tab[exp_id]  = (stim_field(idx, 8) != 0);
    issued_cnt[exp_id]++;
    req_valid_i = 1'b1;
    req_id_i    = id;
    req_addr_i  = addr_t'(stim_field(idx, 2));
    req_op_i    = stim_field(idx, 3);
    req_arga_i  = stim_field(idx, 4);
    req_argb_i  = stim_field(idx, 5);
    do begin
      @(posedge clk_i);
    end while (!req_ready_o);
    pushed_count++;
    @(negedge clk_i);
    req_valid_i = 1'b0;
  endtask

  task automatic wait_responses(input int target);
    while (resp_count < target)
      @(negedge clk_i);
  endtask

  // ----------------------------------------
  // Test sequence
  // ----------------------------------------
  initial begin : main
    int idx;
    $readmemh("offload_input.txt", stim);
    num_req = 0;
    while (num_req < MaxReq && stim_field(num_req, 0) != 32'hf)
      num_req++;
    loaded = 1'b1;
    if (num_req == 0 || num_req == MaxReq) begin
      flow_errors++;
      $display("Stimulus file holds no requests or lacks its end marker");
    end

    // Outputs stay quiet while reset is applied
    repeat (4) @(negedge clk_i);
    if (req_ready_o !== 1'b0)
      note_flow_mismatch("req_ready_o", 0, 32'(req_ready_o));
    if (acc_q_valid_o !== 1'b0)
      note_flow_mismatch("acc_q_valid_o", 0, 32'(acc_q_valid_o));
    if (acc_p_ready_o !== 1'b0)
      note_flow_mismatch("acc_p_ready_o", 0, 32'(acc_p_ready_o));
    if (resp_valid_o !== 1'b0)
      note_flow_mismatch("resp_valid_o", 0, 32'(resp_valid_o));
    @(negedge rst_ni);
    @(negedge clk_i);

    if (flow_errors == 0) begin
      idx       = 0;
      resp_mode = 0;
      // One request at a time
      while (idx < num_req && stim_field(idx, 0) == 0) begin
        push_entry(idx);
        wait_responses(pushed_count);
        idx++;
      end
      // Burst against random response back-pressure
      resp_mode = 1;
      while (idx < num_req && stim_field(idx, 0) == 1) begin
        push_entry(idx);
        idx++;
      end
      wait_responses(pushed_count);
      // Responses stalled until the credits run out
      resp_mode = 2;
      fork
        while (idx < num_req) begin
          push_entry(idx);
          idx++;
        end
        begin
          repeat (StallCycles) @(negedge clk_i);
          if (req_ready_o !== 1'b0)
            note_flow_mismatch("req_ready_o", 0, 32'(req_ready_o));
          if (pushed_count >= num_req) begin
            flow_errors++;
            $display("Every stalled request was accepted, the queue never filled");
          end
          resp_mode = 1;
        end
      join
      wait_responses(pushed_count);
      repeat (20) @(negedge clk_i);
    end

    if (resp_count != pushed_count || pushed_count != num_req) begin
      flow_errors++;
      $display("%0d requests listed, %0d accepted, %0d responses seen",
               num_req, pushed_count, resp_count);
    end
    for (int k = 0; k < 32; k++) begin
      if (issued_cnt[k] != done_cnt[k]) begin
        flow_errors++;
        $display("Response id %0d answered %0d of %0d times", k, done_cnt[k], issued_cnt[k]);
      end
    end

    $display("Errors: %0d response mismatches, %0d unexpected responses, %0d flow failures",
             resp_errors, protocol_errors, flow_errors);
    if (resp_errors == 0 && protocol_errors == 0 && flow_errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  // Watchdog sized from the request count
  initial begin : watchdog
    wait (loaded);
    repeat (num_req * 200 + 1000) @(posedge clk_i);
    $display("Timeout after %0d cycles with requests still outstanding",
             num_req * 200 + 1000);
    $display("Simulation FAILED");
    $finish;
  end

endmodule

// ==== offload_input.txt ====
// phase id addr op arga argb exp_id exp_data exp_error, all hex
// Phase 0 one at a time, 1 burst, 2 stalled burst, f ends the list
0 01 1 1 00000000 00000003 01 00000000 0
0 02 1 1 00000000 00000005 02 00000000 0
0 03 1 2 deadbeef 00000003 00 00000000 0
0 04 1 1 00000000 00000003 04 deadbeef 0
0 05 1 2 12345678 00000003 00 deadbeef 0
0 06 1 2 0000abcd 00000006 00 00000000 0
0 07 1 1 00000000 00000006 07 0000abcd 0
0 08 1 1 00000000 0000000b 08 12345678 0
0 09 0 10 00000005 00000007 09 0000000c 0
0 0a 0 11 ffffffff 00000002 0a 00000001 0
0 0b 2 1 00000000 00000000 0b 00000000 1
0 0c 3 2 00000000 00000000 0c 00000000 1
0 0d 1 7 00000000 00000000 0d 00000000 0
1 10 0 20 00000100 00000023 10 00000123 0
1 11 1 1 00000000 00000003 11 12345678 0
1 12 3 1 00000000 00000000 12 00000000 1
1 13 0 21 7fffffff 00000001 13 80000000 0
1 14 1 1 00000000 00000006 14 0000abcd 0
1 15 0 22 a5a5a5a5 5a5a5a5a 15 ffffffff 0
1 16 2 1 00000000 00000000 16 00000000 1
1 17 0 23 00001000 00002000 17 00003000 0
2 18 1 1 00000000 00000003 18 12345678 0
2 19 2 1 00000000 00000000 19 00000000 1
2 1a 1 1 00000000 00000006 1a 0000abcd 0
2 1b 3 1 00000000 00000000 1b 00000000 1
2 1c 1 1 00000000 00000000 1c 00000000 0
2 1d 0 24 00000011 00000022 1d 00000033 0
2 1e 2 1 00000000 00000000 1e 00000000 1
2 1f 0 25 fffffff0 00000020 1f 00000010 0
f 00 0 0 00000000 00000000 00 00000000 0

// ==== src.f ====
offload_pkg.sv
ssr_cfg_pkg.sv
offload_credit_if.sv
offload_issue.sv
offload_queue.sv
ssr_cfg_unit.sv
offload_dispatch.sv
offload_top.sv
tb_clock_gen.sv
tb_offload_top.sv

// ==== Makefile ====
# Verilator build and run of the offload path testbench

SIM := obj_dir/Vtb_offload_top

all: run

$(SIM): src.f $(wildcard *.sv)
	verilator --binary --timing --timescale 1ns/1ns -j 0 --top-module tb_offload_top -f src.f

# Pass only when the testbench reports success
run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "Simulation PASSED"

clean:
	rm -rf obj_dir

.PHONY: all run clean
